// ==== all.f ====
hdl/lsu_pkg.sv
hdl/hex_seg_decode.sv
hdl/lsu_addr_decode.sv
hdl/lsu_data_mem.sv
hdl/lsu_load_format.sv
hdl/lsu_io_regs.sv
hdl/lsu.sv
+incdir+tb
tb/lsu_tb.sv

// ==== tb/lsu_tb_tasks.svh ====
`ifndef LSU_TB_TASKS_SVH
`define LSU_TB_TASKS_SVH

task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
	if (act !== exp) begin
		errors++;
		$display("[FAIL] %s expected %h got %h", name, exp, act);
	end
endtask

task automatic check_seg(input string name, input logic [6:0] exp, input logic [6:0] act);
	if (act !== exp) begin
		errors++;
		$display("[FAIL] %s expected %h got %h", name, exp, act);
	end
endtask

// Write level held for one cycle, lands on the second edge
task automatic drive_store(input logic [31:0] addr, input logic [31:0] data,
		input lsu_pkg::access_size_t size);
	@(posedge clk);
	lsu_addr <= addr;
	st_data  <= data;
	bmask    <= size;
	wren     <= 1'b1;
	@(posedge clk);
	wren     <= 1'b0;
endtask

// Load path is combinational, sampled mid-cycle
task automatic check_load(input logic [31:0] addr, input lsu_pkg::load_sel_t sel,
		input logic [31:0] exp);
	@(posedge clk);
	lsu_addr <= addr;
	sl_sel   <= sel;
	wren     <= 1'b0;
	@(negedge clk);
	check_word($sformatf("o_ld_data (addr %h sel %0d)", addr, sel), exp, ld_data);
endtask

// Byte image update, misaligned stores are dropped
function automatic void model_write(input logic [31:0] addr, input logic [31:0] data,
		input lsu_pkg::access_size_t size);
	int idx;
	idx = int'(addr & (MEM_BYTES - 1));
	case (size)
		lsu_pkg::SIZE_BYTE: mem_model[idx] = data[7:0];
		lsu_pkg::SIZE_HALF: if (!addr[0]) begin
			mem_model[idx]   = data[7:0];
			mem_model[idx+1] = data[15:8];
		end
		lsu_pkg::SIZE_WORD: if (addr[1:0] == 2'b00) begin
			for (int k = 0; k < 4; k++) mem_model[idx+k] = data[8*k +: 8];
		end
		default: ;
	endcase
endfunction

function automatic logic [31:0] model_load(input logic [31:0] addr,
		input lsu_pkg::load_sel_t sel);
	int          idx;
	logic [7:0]  b;
	logic [15:0] h;
	logic [31:0] w;
	idx = int'(addr & (MEM_BYTES - 1));
	b   = mem_model[idx];
	h   = {mem_model[(idx & ~1) + 1], mem_model[idx & ~1]};
	w   = {mem_model[(idx & ~3) + 3], mem_model[(idx & ~3) + 2],
	       mem_model[(idx & ~3) + 1], mem_model[idx & ~3]};
	case (sel)
		lsu_pkg::LD_B:  return {{24{b[7]}}, b}; // Sign from bit 7
		lsu_pkg::LD_BU: return {24'h0, b};
		lsu_pkg::LD_H:  return {{16{h[15]}}, h};
		lsu_pkg::LD_HU: return {16'h0, h};
		default:        return w;
	endcase
endfunction

task automatic mem_store(input logic [31:0] addr, input logic [31:0] data,
		input lsu_pkg::access_size_t size);
	drive_store(addr, data, size);
	model_write(addr, data, size);
endtask

// Four glyph bytes, lowest digit in byte 0
function automatic logic [31:0] expected_hex_word(input int first);
	logic [31:0] w;
	w = '0;
	for (int k = 0; k < 4; k++) w[8*k +: 7] = lsu_pkg::SEG_TABLE[exp_nib[first+k]];
	return w;
endfunction

task automatic check_io_outputs();
	@(negedge clk);
	check_word("o_io_ledr", exp_ledr, io_ledr);
	check_word("o_io_ledg", exp_ledg, io_ledg);
	check_word("o_io_lcd", exp_lcd, io_lcd);
	for (int k = 0; k < 8; k++) begin
		check_seg($sformatf("o_io_hex%0d", k), lsu_pkg::SEG_TABLE[exp_nib[k]], hex[k]);
	end
endtask

`endif

// ==== tb/lsu_tb.sv ====
`timescale 1ns/100ps

module lsu_tb;

	localparam int MEM_DEPTH      = 2048;
	localparam int MEM_BYTES      = MEM_DEPTH * 4;
	localparam int RAND_WORDS     = 128;                    // Words touched by random traffic
	localparam int RAND_STRIDE    = MEM_DEPTH / RAND_WORDS; // Spread over whole depth
	localparam int TEST_CYCLES    = 1000;                   // Rough sum of all tests
	localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES;
	localparam logic [31:0] UNMAPPED_ADDR = 32'h2000_0100;   // Low bits alias word 0x40

	logic                  clk;
	logic                  reset_n;
	logic [31:0]           lsu_addr;
	logic [31:0]           st_data;
	logic                  wren;
	logic [31:0]           io_sw;
	lsu_pkg::access_size_t bmask;
	lsu_pkg::load_sel_t    sl_sel;
	logic [1:0]            io_key;
	logic [31:0]           ld_data, io_ledr, io_ledg, io_lcd;
	logic [6:0]            hex [8];

	logic [7:0]  mem_model [MEM_BYTES]; // Expected memory bytes
	logic [31:0] exp_ledr, exp_ledg, exp_lcd;
	logic [3:0]  exp_nib [8];           // Expected digit values
	int          errors = 0;
	int          cycles = 0;

	lsu #(.MEM_DEPTH_WORDS(MEM_DEPTH)) dut0 (
		.i_clk (clk), .i_reset (reset_n), .i_lsu_addr (lsu_addr), .i_st_data (st_data),
		.i_lsu_wren (wren), .i_io_sw (io_sw), .i_bmask (bmask), .i_sl_sel (sl_sel),
		.i_io_key (io_key), .o_ld_data (ld_data), .o_io_ledr (io_ledr),
		.o_io_ledg (io_ledg), .o_io_hex0 (hex[0]), .o_io_hex1 (hex[1]),
		.o_io_hex2 (hex[2]), .o_io_hex3 (hex[3]), .o_io_hex4 (hex[4]),
		.o_io_hex5 (hex[5]), .o_io_hex6 (hex[6]), .o_io_hex7 (hex[7]), .o_io_lcd (io_lcd)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk; // 4 ns period

	`include "lsu_tb_tasks.svh"

	// Every width and sign at each naturally aligned offset of one word
	task automatic load_all_sels(input logic [31:0] base);
		for (int off = 0; off < 4; off++) begin
			check_load(base + off, lsu_pkg::LD_B, model_load(base + off, lsu_pkg::LD_B));
			check_load(base + off, lsu_pkg::LD_BU, model_load(base + off, lsu_pkg::LD_BU));
		end
		for (int off = 0; off < 4; off += 2) begin
			check_load(base + off, lsu_pkg::LD_H, model_load(base + off, lsu_pkg::LD_H));
			check_load(base + off, lsu_pkg::LD_HU, model_load(base + off, lsu_pkg::LD_HU));
		end
		check_load(base, lsu_pkg::LD_W, model_load(base, lsu_pkg::LD_W));
	endtask

	task automatic test_mem_store_load();
		mem_store(32'h0000_0100, 32'h8765_43F1, lsu_pkg::SIZE_WORD);
		load_all_sels(32'h0000_0100);
		mem_store(32'h0000_0102, 32'hFFFF_A5C3, lsu_pkg::SIZE_HALF); // Upper half only
		mem_store(32'h0000_0101, 32'h0000_0080, lsu_pkg::SIZE_BYTE);
		mem_store(32'h0000_0104, 32'h7FFF_0001, lsu_pkg::SIZE_WORD);
		mem_store(32'h0000_0104, 32'h0000_8000, lsu_pkg::SIZE_HALF);
		load_all_sels(32'h0000_0100);
		load_all_sels(32'h0000_0104);
		mem_store((MEM_DEPTH - 1) * 4, 32'hC001_D00D, lsu_pkg::SIZE_WORD); // Last word
		load_all_sels((MEM_DEPTH - 1) * 4);
	endtask

	task automatic test_led_lcd();
		drive_store(lsu_pkg::ADDR_LEDR_BASE, 32'hFFFF_FFFF, lsu_pkg::SIZE_WORD);
		exp_ledr = 32'h0001_FFFF; // 17 LEDs
		drive_store(lsu_pkg::ADDR_LEDG_BASE + 4, 32'h1234_56A7, lsu_pkg::SIZE_WORD);
		exp_ledg = 32'h0000_00A7;
		drive_store(lsu_pkg::ADDR_LCD_BASE, 32'hDEAD_BEEF, lsu_pkg::SIZE_WORD);
		exp_lcd  = 32'hDEAD_BEEF;
		check_io_outputs();
		check_load(lsu_pkg::ADDR_LEDR_BASE, lsu_pkg::LD_W, exp_ledr);
		check_load(lsu_pkg::ADDR_LEDG_BASE, lsu_pkg::LD_W, exp_ledg);
		check_load(lsu_pkg::ADDR_LCD_BASE + 8, lsu_pkg::LD_W, exp_lcd);
		drive_store(lsu_pkg::ADDR_LEDG_BASE, 32'h0000_005A, lsu_pkg::SIZE_BYTE);
		exp_ledg = 32'h0000_005A;
		check_io_outputs();
		check_load(lsu_pkg::ADDR_LEDG_BASE, lsu_pkg::LD_W, exp_ledg);
	endtask

	task automatic test_hex_digits();
		logic [31:0] lo_word, hi_word;
		lo_word = 32'hCAFE_9A3B;
		hi_word = 32'h0000_F1D4;
		drive_store(lsu_pkg::ADDR_HEX03_BASE, lo_word, lsu_pkg::SIZE_WORD);
		drive_store(lsu_pkg::ADDR_HEX47_BASE, hi_word, lsu_pkg::SIZE_WORD);
		for (int k = 0; k < 4; k++) begin
			exp_nib[k]   = lo_word[4*k +: 4];
			exp_nib[k+4] = hi_word[4*k +: 4];
		end
		check_io_outputs();
		check_load(lsu_pkg::ADDR_HEX03_BASE, lsu_pkg::LD_W, expected_hex_word(0));
		check_load(lsu_pkg::ADDR_HEX47_BASE, lsu_pkg::LD_W, expected_hex_word(4));
		drive_store(lsu_pkg::ADDR_HEX03_BASE, 32'h0000_0077, lsu_pkg::SIZE_BYTE); // Ignored
		drive_store(lsu_pkg::ADDR_HEX47_BASE, 32'h0000_5555, lsu_pkg::SIZE_HALF); // Ignored
		check_io_outputs();
		check_load(lsu_pkg::ADDR_HEX03_BASE, lsu_pkg::LD_W, expected_hex_word(0));
	endtask

	task automatic test_inputs_unmapped();
		@(posedge clk);
		io_sw  <= 32'h1357_9BDF;
		io_key <= 2'b10;
		check_load(lsu_pkg::ADDR_SW_BASE, lsu_pkg::LD_W, 32'h1357_9BDF);
		check_load(lsu_pkg::ADDR_KEY_BASE, lsu_pkg::LD_W, 32'h0000_0002);
		check_load(UNMAPPED_ADDR, lsu_pkg::LD_W, 32'h0000_0000);
		check_load(32'h1000_6000, lsu_pkg::LD_W, 32'h0000_0000); // Gap in IO space
		drive_store(lsu_pkg::ADDR_SW_BASE + 32'h100, 32'hFFFF_FFFF, lsu_pkg::SIZE_WORD);
		drive_store(lsu_pkg::ADDR_KEY_BASE, 32'hFFFF_FFFF, lsu_pkg::SIZE_WORD);
		drive_store(UNMAPPED_ADDR, 32'h0BAD_F00D, lsu_pkg::SIZE_WORD);
		check_io_outputs();
		check_load(32'h0000_0100, lsu_pkg::LD_W, model_load(32'h0000_0100, lsu_pkg::LD_W));
		check_load(lsu_pkg::ADDR_SW_BASE, lsu_pkg::LD_W, 32'h1357_9BDF);
	endtask

	task automatic test_random_traffic();
		logic [31:0] addr;
		int          pick;
		for (int w = 0; w < RAND_WORDS; w++) begin
			mem_store(w * RAND_STRIDE * 4, $urandom, lsu_pkg::SIZE_WORD); // Known contents
		end
		repeat (300) begin
			addr = ($urandom % RAND_WORDS) * RAND_STRIDE * 4;
			pick = $urandom % 8;
			case (pick)
				0: mem_store(addr + $urandom % 4, $urandom, lsu_pkg::SIZE_BYTE);
				1: mem_store(addr + ($urandom % 2) * 2, $urandom, lsu_pkg::SIZE_HALF);
				2: mem_store(addr, $urandom, lsu_pkg::SIZE_WORD);
				3: check_load(addr + 1, lsu_pkg::LD_B, model_load(addr + 1, lsu_pkg::LD_B));
				4: check_load(addr + 3, lsu_pkg::LD_BU, model_load(addr + 3, lsu_pkg::LD_BU));
				5: check_load(addr + 2, lsu_pkg::LD_H, model_load(addr + 2, lsu_pkg::LD_H));
				6: check_load(addr, lsu_pkg::LD_HU, model_load(addr, lsu_pkg::LD_HU));
				default: check_load(addr, lsu_pkg::LD_W, model_load(addr, lsu_pkg::LD_W));
			endcase
		end
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, tests did not complete (%0d errors)",
				cycles, errors);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	initial begin
		void'($urandom(32'h6422_0fa8));
		reset_n  = 1'b0;
		lsu_addr = '0;
		st_data  = '0;
		wren     = 1'b0;
		io_sw    = '0;
		io_key   = 2'b00;
		bmask    = lsu_pkg::SIZE_WORD;
		sl_sel   = lsu_pkg::LD_W;
		exp_ledr = '0;
		exp_ledg = '0;
		exp_lcd  = '0;
		for (int k = 0; k < 8; k++) exp_nib[k] = 4'h0; // Digits show 0 after reset
		repeat (10) @(posedge clk);
		reset_n <= 1'b1;
		check_io_outputs();
		test_mem_store_load();
		test_led_lcd();
		test_hex_digits();
		test_inputs_unmapped();
		test_random_traffic();
		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// ==== hdl/lsu.sv ====
`timescale 1ns/100ps

module lsu #(
	parameter int MEM_DEPTH_WORDS = 2048 // Data memory size in words
) (
	input  logic                  i_clk,      // Rising edge clock
	input  logic                  i_reset,    // Async reset, active low
	input  logic [31:0]           i_lsu_addr, // Load/store address
	input  logic [31:0]           i_st_data,  // Store data
	input  logic                  i_lsu_wren, // Store when high
	input  logic [31:0]           i_io_sw,    // Switches
	input  lsu_pkg::access_size_t i_bmask,    // Store width
	input  lsu_pkg::load_sel_t    i_sl_sel,   // Load width and sign
	input  logic [1:0]            i_io_key,   // Keys
	output logic [31:0]           o_ld_data,  // Load result
	output logic [31:0]           o_io_ledr,  // Red LEDs
	output logic [31:0]           o_io_ledg,  // Green LEDs
	output logic [6:0]            o_io_hex0,  // Seven-segment digits
	output logic [6:0]            o_io_hex1,
	output logic [6:0]            o_io_hex2,
	output logic [6:0]            o_io_hex3,
	output logic [6:0]            o_io_hex4,
	output logic [6:0]            o_io_hex5,
	output logic [6:0]            o_io_hex6,
	output logic [6:0]            o_io_hex7,
	output logic [31:0]           o_io_lcd    // LCD word
);

	logic [7:0]  region;     // One-hot page hit
	logic [1:0]  byte_off;
	logic [31:0] mem_word;   // Raw memory word
	logic [31:0] io_rd_data; // Output register read-back

	lsu_addr_decode u_decode (
		.i_addr     (i_lsu_addr),
		.o_region   (region),
		.o_byte_off (byte_off)
	);

	lsu_data_mem #(
		.MEM_DEPTH_WORDS (MEM_DEPTH_WORDS)
	) u_mem (
		.i_clk     (i_clk),
		.i_addr    (i_lsu_addr),
		.i_st_data (i_st_data),
		.i_size    (i_bmask),
		.i_wren    (i_lsu_wren),
		.i_sel_mem (region[lsu_pkg::REG_MEM]),
		.o_word    (mem_word)
	);

	lsu_load_format u_format (
		.i_word       (mem_word),
		.i_byte_off   (byte_off),
		.i_sl_sel     (i_sl_sel),
		.i_region     (region),
		.i_io_rd_data (io_rd_data),
		.i_io_sw      (i_io_sw),
		.i_io_key     (i_io_key),
		.o_ld_data    (o_ld_data)
	);

	lsu_io_regs u_io (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_wren       (i_lsu_wren),
		.i_region     (region),
		.i_size       (i_bmask),
		.i_st_data    (i_st_data),
		.o_io_ledr    (o_io_ledr),
		.o_io_ledg    (o_io_ledg),
		.o_io_lcd     (o_io_lcd),
		.o_io_hex0    (o_io_hex0),
		.o_io_hex1    (o_io_hex1),
		.o_io_hex2    (o_io_hex2),
		.o_io_hex3    (o_io_hex3),
		.o_io_hex4    (o_io_hex4),
		.o_io_hex5    (o_io_hex5),
		.o_io_hex6    (o_io_hex6),
		.o_io_hex7    (o_io_hex7),
		.o_io_rd_data (io_rd_data)
	);

endmodule

// ==== hdl/lsu_io_regs.sv ====
`timescale 1ns/100ps

module lsu_io_regs (
	input  logic                  i_clk,        // Register clock
	input  logic                  i_reset,      // Async reset, active low
	input  logic                  i_wren,       // Store level from the core
	input  logic [7:0]            i_region,     // One-hot region select
	input  lsu_pkg::access_size_t i_size,       // Store width
	input  logic [31:0]           i_st_data,    // Store data
	output logic [31:0]           o_io_ledr,    // Red LEDs
	output logic [31:0]           o_io_ledg,    // Green LEDs
	output logic [31:0]           o_io_lcd,     // LCD control word
	output logic [6:0]            o_io_hex0,    // Digit 0, active low
	output logic [6:0]            o_io_hex1,
	output logic [6:0]            o_io_hex2,
	output logic [6:0]            o_io_hex3,
	output logic [6:0]            o_io_hex4,
	output logic [6:0]            o_io_hex5,
	output logic [6:0]            o_io_hex6,
	output logic [6:0]            o_io_hex7,    // Digit 7
	output logic [31:0]           o_io_rd_data  // Read-back for loads
);

	logic [16:0] ledr_q;    // 17 red LEDs
	logic [7:0]  ledg_q;    // 8 green LEDs
	logic [31:0] lcd_q;
	logic [3:0]  nib_q [8]; // Digit values
	logic [6:0]  seg [8];   // Decoded glyphs
	logic        hex_word;  // Hex pages only take full words

	assign hex_word = i_wren && (i_size == lsu_pkg::SIZE_WORD);

	always_ff @(posedge i_clk or negedge i_reset) begin
		if (!i_reset) begin
			ledr_q <= '0;
			ledg_q <= '0;
			lcd_q  <= '0;
		end else if (i_wren) begin
			if (i_region[lsu_pkg::REG_LEDR]) ledr_q <= i_st_data[16:0];
			if (i_region[lsu_pkg::REG_LEDG]) ledg_q <= i_st_data[7:0];
			if (i_region[lsu_pkg::REG_LCD])  lcd_q  <= i_st_data;
		end
	end

	// Nibble k of the low half goes to digit k, or k+4 for the upper page
	always_ff @(posedge i_clk or negedge i_reset) begin
		if (!i_reset) begin
			for (int k = 0; k < 8; k++) begin
				nib_q[k] <= 4'h0; // Shows 0 out of reset
			end
		end else begin
			for (int k = 0; k < 4; k++) begin
				if (hex_word && i_region[lsu_pkg::REG_HEX03]) nib_q[k]   <= i_st_data[4*k +: 4];
				if (hex_word && i_region[lsu_pkg::REG_HEX47]) nib_q[k+4] <= i_st_data[4*k +: 4];
			end
		end
	end

	for (genvar g = 0; g < 8; g++) begin : g_digit
		hex_seg_decode u_seg (
			.i_nibble (nib_q[g]),
			.o_seg    (seg[g])
		);
	end

	assign o_io_ledr = {15'h0, ledr_q};
	assign o_io_ledg = {24'h0, ledg_q};
	assign o_io_lcd  = lcd_q;
	assign o_io_hex0 = seg[0];
	assign o_io_hex1 = seg[1];
	assign o_io_hex2 = seg[2];
	assign o_io_hex3 = seg[3];
	assign o_io_hex4 = seg[4];
	assign o_io_hex5 = seg[5];
	assign o_io_hex6 = seg[6];
	assign o_io_hex7 = seg[7];

	always_comb begin
		o_io_rd_data = 32'h0; // Inputs and memory come from elsewhere
		if (i_region[lsu_pkg::REG_LEDR])  o_io_rd_data = o_io_ledr;
		if (i_region[lsu_pkg::REG_LEDG])  o_io_rd_data = o_io_ledg;
		if (i_region[lsu_pkg::REG_LCD])   o_io_rd_data = lcd_q;
		if (i_region[lsu_pkg::REG_HEX03]) o_io_rd_data = {1'b0, seg[3], 1'b0, seg[2],
		                                                  1'b0, seg[1], 1'b0, seg[0]};
		if (i_region[lsu_pkg::REG_HEX47]) o_io_rd_data = {1'b0, seg[7], 1'b0, seg[6],
		                                                  1'b0, seg[5], 1'b0, seg[4]};
	end

	// Overlapping pages in the decoder would corrupt both stores and read-back
	a_region_onehot: assert property (
		@(posedge i_clk) disable iff (!i_reset) $onehot0(i_region)
	) else $error("region select not one-hot: %b", i_region);

endmodule

// ==== hdl/lsu_load_format.sv ====
`timescale 1ns/100ps

module lsu_load_format (
	input  logic [31:0]        i_word,       // Aligned memory word
	input  logic [1:0]         i_byte_off,   // Offset of addressed byte
	input  lsu_pkg::load_sel_t i_sl_sel,     // Load width and signedness
	input  logic [7:0]         i_region,     // One-hot region select
	input  logic [31:0]        i_io_rd_data, // Output register read-back
	input  logic [31:0]        i_io_sw,      // Switches
	input  logic [1:0]         i_io_key,     // Keys
	output logic [31:0]        o_ld_data     // Load result to the core
);

	logic [31:0] shifted; // Addressed byte moved to bit 0
	logic [7:0]  ld_byte;
	logic [15:0] ld_half;
	logic [31:0] mem_ld;  // Extended memory load

	assign shifted = i_word >> {i_byte_off, 3'b000};
	assign ld_byte = shifted[7:0];
	assign ld_half = shifted[15:0]; // Offset 2 lands the upper half here

	always_comb begin
		case (i_sl_sel)
			lsu_pkg::LD_B:  mem_ld = {{24{ld_byte[7]}}, ld_byte};
			lsu_pkg::LD_BU: mem_ld = {24'h0, ld_byte};
			lsu_pkg::LD_H:  mem_ld = {{16{ld_half[15]}}, ld_half};
			lsu_pkg::LD_HU: mem_ld = {16'h0, ld_half};
			lsu_pkg::LD_W:  mem_ld = i_word;
			default:        mem_ld = i_word; // Unused funct3 treated as word
		endcase
	end

	// Source select, output regions share one read-back word
	always_comb begin
		if (i_region[lsu_pkg::REG_MEM]) begin
			o_ld_data = mem_ld;
		end else if (i_region[lsu_pkg::REG_SW]) begin
			o_ld_data = i_io_sw;
		end else if (i_region[lsu_pkg::REG_KEY]) begin
			o_ld_data = {30'h0, i_io_key};
		end else if (|i_region) begin
			o_ld_data = i_io_rd_data; // LEDR, LEDG, hex or LCD
		end else begin
			o_ld_data = 32'h0;        // Unmapped
		end
	end

endmodule

// ==== hdl/lsu_data_mem.sv ====
`timescale 1ns/100ps

module lsu_data_mem #(
	parameter int MEM_DEPTH_WORDS = 2048 // Words per byte lane
) (
	input  logic                  i_clk,     // Store clock
	input  logic [31:0]           i_addr,    // Byte address
	input  logic [31:0]           i_st_data, // Store data, right aligned
	input  lsu_pkg::access_size_t i_size,    // Store width
	input  logic                  i_wren,    // Store level from the core
	input  logic                  i_sel_mem, // Address hits memory page
	output logic [31:0]           o_word     // Aligned word at address
);

	localparam int IDX_W = $clog2(MEM_DEPTH_WORDS); // Word index width

	logic [IDX_W-1:0] word_idx;   // Word slot in every lane
	logic [1:0]       byte_off;   // First byte of the access
	logic [3:0]       lane_strb;  // Lanes touched by the store
	logic [31:0]      lane_data;  // Store data replicated to lanes
	logic             misaligned; // Access crosses its natural boundary
	logic             mem_we;     // Qualified memory write

	assign word_idx = i_addr[IDX_W+1:2]; // Upper bits dropped, wraps modulo depth
	assign byte_off = i_addr[1:0];

	always_comb begin
		lane_strb  = 4'b0000;
		lane_data  = i_st_data;
		misaligned = 1'b0;
		case (i_size)
			lsu_pkg::SIZE_BYTE: begin
				lane_strb = 4'b0001 << byte_off;     // Any offset is fine
				lane_data = {4{i_st_data[7:0]}};     // Byte on every lane
			end
			lsu_pkg::SIZE_HALF: begin
				misaligned = byte_off[0];            // Odd half
				lane_strb  = byte_off[1] ? 4'b1100 : 4'b0011;
				lane_data  = {2{i_st_data[15:0]}};   // Half on both halves
			end
			lsu_pkg::SIZE_WORD: begin
				misaligned = (byte_off != 2'b00);    // Word must start lane 0
				lane_strb  = 4'b1111;
			end
			default: begin
				lane_strb = 4'b0000;                 // Unknown width writes nothing
			end
		endcase
	end

	// Misaligned stores are dropped rather than split
	assign mem_we = i_wren & i_sel_mem & ~misaligned;

	for (genvar g = 0; g < 4; g++) begin : g_lane
		logic [7:0] ram [MEM_DEPTH_WORDS]; // Byte lane g

		always_ff @(posedge i_clk) begin
			if (mem_we && lane_strb[g]) begin
				ram[word_idx] <= lane_data[8*g +: 8];
			end
		end

		assign o_word[8*g +: 8] = ram[word_idx]; // Async read, same-cycle load
	end

	// The core is expected never to issue a misaligned memory store
	a_store_aligned: assert property (
		@(posedge i_clk) (i_wren && i_sel_mem) |-> !misaligned
	) else $error("misaligned store to data memory, addr %h size %b", i_addr, i_size);

endmodule

// ==== hdl/lsu_addr_decode.sv ====
`timescale 1ns/100ps

module lsu_addr_decode (
	input  logic [31:0] i_addr,     // Data address from the core
	output logic [7:0]  o_region,   // One-hot region select
	output logic [1:0]  o_byte_off  // Offset inside the word
);

	localparam logic [31:0] MEM_PAGE_MASK = 32'hFFFF_0000; // 64 KiB granularity
	localparam logic [31:0] IO_PAGE_MASK  = 32'hFFFF_F000; // 4 KiB granularity

	logic [31:0] mem_page; // Address cut to memory page
	logic [31:0] io_page;  // Address cut to IO page

	assign mem_page = i_addr & MEM_PAGE_MASK;
	assign io_page  = i_addr & IO_PAGE_MASK;

	// Each page matches at most one base, so the vector stays one-hot or zero
	assign o_region[lsu_pkg::REG_MEM] =
		(mem_page == lsu_pkg::ADDR_MEM_BASE);
	assign o_region[lsu_pkg::REG_LEDR] =
		(io_page == lsu_pkg::ADDR_LEDR_BASE);
	assign o_region[lsu_pkg::REG_LEDG] =
		(io_page == lsu_pkg::ADDR_LEDG_BASE);
	assign o_region[lsu_pkg::REG_HEX03] =
		(io_page == lsu_pkg::ADDR_HEX03_BASE);
	assign o_region[lsu_pkg::REG_HEX47] =
		(io_page == lsu_pkg::ADDR_HEX47_BASE);
	assign o_region[lsu_pkg::REG_LCD] =
		(io_page == lsu_pkg::ADDR_LCD_BASE);
	assign o_region[lsu_pkg::REG_SW] =
		(io_page == lsu_pkg::ADDR_SW_BASE);
	assign o_region[lsu_pkg::REG_KEY] =
		(io_page == lsu_pkg::ADDR_KEY_BASE);

	assign o_byte_off = i_addr[1:0]; // Lane of the first byte

endmodule

// ==== hdl/hex_seg_decode.sv ====
`timescale 1ns/100ps

module hex_seg_decode (
	input  logic [3:0] i_nibble, // Digit value
	output logic [6:0] o_seg     // Segments g..a, active low
);

	always_comb begin
		case (i_nibble)
			4'h0: o_seg = lsu_pkg::SEG_TABLE[0];
			4'h1: o_seg = lsu_pkg::SEG_TABLE[1];
			4'h2: o_seg = lsu_pkg::SEG_TABLE[2];
			4'h3: o_seg = lsu_pkg::SEG_TABLE[3];
			4'h4: o_seg = lsu_pkg::SEG_TABLE[4];
			4'h5: o_seg = lsu_pkg::SEG_TABLE[5];
			4'h6: o_seg = lsu_pkg::SEG_TABLE[6];
			4'h7: o_seg = lsu_pkg::SEG_TABLE[7];
			4'h8: o_seg = lsu_pkg::SEG_TABLE[8];
			4'h9: o_seg = lsu_pkg::SEG_TABLE[9];
			4'hA: o_seg = lsu_pkg::SEG_TABLE[10]; // Letters from here on
			4'hB: o_seg = lsu_pkg::SEG_TABLE[11]; // Lower case b
			4'hC: o_seg = lsu_pkg::SEG_TABLE[12];
			4'hD: o_seg = lsu_pkg::SEG_TABLE[13]; // Lower case d
			4'hE: o_seg = lsu_pkg::SEG_TABLE[14];
			4'hF: o_seg = lsu_pkg::SEG_TABLE[15];
		endcase
	end

endmodule

// ==== hdl/lsu_pkg.sv ====
package lsu_pkg;

	// Region starts, memory is one 64 KiB page and each IO block one 4 KiB page
	localparam logic [31:0] ADDR_MEM_BASE   = 32'h0000_0000; // Data memory
	localparam logic [31:0] ADDR_LEDR_BASE  = 32'h1000_0000; // Red LEDs
	localparam logic [31:0] ADDR_LEDG_BASE  = 32'h1000_1000; // Green LEDs
	localparam logic [31:0] ADDR_HEX03_BASE = 32'h1000_2000; // Hex digits 3..0
	localparam logic [31:0] ADDR_HEX47_BASE = 32'h1000_3000; // Hex digits 7..4
	localparam logic [31:0] ADDR_LCD_BASE   = 32'h1000_4000; // LCD word
	localparam logic [31:0] ADDR_KEY_BASE   = 32'h1000_5000; // Push keys
	localparam logic [31:0] ADDR_SW_BASE    = 32'h1001_0000; // Slide switches

	// Bit positions inside the one-hot region vector
	localparam int REG_MEM   = 0;
	localparam int REG_LEDR  = 1;
	localparam int REG_LEDG  = 2;
	localparam int REG_HEX03 = 3;
	localparam int REG_HEX47 = 4;
	localparam int REG_LCD   = 5;
	localparam int REG_SW    = 6;
	localparam int REG_KEY   = 7;

	typedef enum logic [2:0] {
		SIZE_BYTE = 3'b001, // Single lane
		SIZE_HALF = 3'b010, // Two lanes
		SIZE_WORD = 3'b100  // All four lanes
	} access_size_t;

	// Same coding as RISC-V funct3 for loads
	typedef enum logic [2:0] {
		LD_B  = 3'b000, // Signed byte
		LD_H  = 3'b001, // Signed half
		LD_W  = 3'b010, // Full word
		LD_BU = 3'b100, // Unsigned byte
		LD_HU = 3'b101  // Unsigned half
	} load_sel_t;

	// Active-low glyphs, bit 0 is segment a
	localparam logic [6:0] SEG_TABLE [16] = '{
		7'h40, 7'h79, 7'h24, 7'h30, // 0 1 2 3
		7'h19, 7'h12, 7'h02, 7'h78, // 4 5 6 7
		7'h00, 7'h10, 7'h08, 7'h03, // 8 9 A b
		7'h46, 7'h21, 7'h06, 7'h0E  // C d E F
	};

endpackage
